/* Makefile */
VERILATOR ?= verilator
TOP       ?= pipeline_wrapper_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* sim/pipeline_wrapper_assertions.sv */
module pipeline_wrapper_assertions (
    input logic                        clk_i,
    input logic                        rst_n_i,
    input logic                        ex_we_i,
    input backend_data_pkg::reg_addr_t ex_waddr_i,
    input logic                        mem_we_i,
    input backend_data_pkg::reg_addr_t mem_waddr_i,
    input logic                        rvm_we_i,
    input backend_data_pkg::reg_addr_t rvm_waddr_i
);
    // Two result ports must never target one register together
    ex_mem_clash: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(ex_we_i && mem_we_i && ex_waddr_i != '0 && ex_waddr_i == mem_waddr_i))
        else $error("EX and MEM write the same register in one cycle");

    ex_rvm_clash: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(ex_we_i && rvm_we_i && ex_waddr_i != '0 && ex_waddr_i == rvm_waddr_i))
        else $error("EX and RVM write the same register in one cycle");

    mem_rvm_clash: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(mem_we_i && rvm_we_i && mem_waddr_i != '0 && mem_waddr_i == rvm_waddr_i))
        else $error("MEM and RVM write the same register in one cycle");

    we_low_after_reset: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> !(ex_we_i || mem_we_i || rvm_we_i))
        else $error("Write enable high in the first cycle after reset");
endmodule : pipeline_wrapper_assertions

bind pipeline_wrapper pipeline_wrapper_assertions u_assertions (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .ex_we_i     (ex_we_o),
    .ex_waddr_i  (ex_waddr_o),
    .mem_we_i    (mem_we_o),
    .mem_waddr_i (mem_waddr_o),
    .rvm_we_i    (rvm_we_o),
    .rvm_waddr_i (rvm_waddr_o)
);

/* sim/pipeline_wrapper_tb.sv */
module pipeline_wrapper_tb;
    import backend_op_pkg::*;
    import backend_data_pkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 3;
    localparam int MEM_DEPTH_WORDS = 256;
    localparam int RVM_STAGES      = 5;
    localparam int IDX_W           = $clog2(MEM_DEPTH_WORDS);
    localparam int DRAIN_CYCLES    = RVM_STAGES + 1;
    localparam int N_ALU           = 40;
    localparam int N_BRANCH        = 30;
    localparam int N_MEM_INIT      = MEM_DEPTH_WORDS;
    localparam int N_MEM           = 60;
    localparam int N_MUL           = 20;
    localparam int N_FWD           = 200;
    localparam int N_REPORT        = 150;
    localparam int TOTAL_CYCLES    = N_ALU + N_BRANCH + N_MEM_INIT + N_MEM + N_MUL + N_FWD
                                   + N_REPORT + 6 * DRAIN_CYCLES;
    localparam int MARGIN_CYCLES   = 100;

    typedef struct packed {
        pipe_sel_e   pipe;
        alu_op_e     alu;
        rvm_op_e     rvm;
        logic        rd;
        logic        wr;
        mem_size_e   size;
        logic        sign;
        word_t       a;
        word_t       b;
        word_t       st;
        pc_t         base;
        pc_t         off;
        bypass_sel_e bya;
        bypass_sel_e byb;
        logic        we;
        reg_addr_t   waddr;
    } op_t;

    logic        clk_i = 1'b0;
    logic        rst_n_i;
    pipe_sel_e   pipe_i;
    alu_op_e     alu_op_i;
    rvm_op_e     rvm_op_i;
    logic        mem_rd_i;
    logic        mem_wr_i;
    mem_size_e   mem_size_i;
    logic        mem_sign_ext_i;
    word_t       src_a_i;
    word_t       src_b_i;
    word_t       st_data_i;
    pc_t         br_base_i;
    pc_t         br_offset_i;
    bypass_sel_e bypass_a_i;
    bypass_sel_e bypass_b_i;
    logic        rf_we_i;
    reg_addr_t   rf_waddr_i;
    word_t       ex_data_o;
    logic        ex_we_o;
    reg_addr_t   ex_waddr_o;
    word_t       mem_data_o;
    logic        mem_we_o;
    reg_addr_t   mem_waddr_o;
    word_t       rvm_data_o;
    logic        rvm_we_o;
    reg_addr_t   rvm_waddr_o;
    logic        branch_completed_o;
    logic        tkbr_o;
    pc_t         new_pc_o;
    reg_addr_t   byp_ex_wreg_o;
    reg_addr_t   byp_alu_mem_wreg_o;
    reg_addr_t   byp_mem_wreg_o;
    reg_addr_t   byp_rvm_wreg_o [1:RVM_STAGES];
    word_t       byp_ex_data_o;
    word_t       byp_mem_data_o;
    word_t       byp_rvm5_data_o;

    // Reference model state after each rising edge
    op_t              app;
    logic             m_ex_we;
    reg_addr_t        m_ex_waddr;
    word_t            m_ex_data;
    logic             m_br_done;
    logic             m_tkbr;
    pc_t              m_new_pc;
    logic             m_s1_rd;
    logic             m_s1_wr;
    logic             m_s1_we;
    reg_addr_t        m_s1_waddr;
    logic [IDX_W-1:0] m_s1_idx;
    logic [1:0]       m_s1_lane;
    mem_size_e        m_s1_size;
    logic             m_s1_sign;
    word_t            m_s1_st;
    logic             m_mem_we;
    reg_addr_t        m_mem_waddr;
    word_t            m_mem_data;
    logic             m_rvm_we    [1:RVM_STAGES];
    reg_addr_t        m_rvm_waddr [1:RVM_STAGES];
    word_t            m_rvm_res   [1:RVM_STAGES];
    word_t            model_mem   [MEM_DEPTH_WORDS];

    string cur_test;
    int    num_tests;
    int    num_checks;
    int    num_errors;
    int    errs_at_start;

    pipeline_wrapper #(
        .MEM_DEPTH_WORDS (MEM_DEPTH_WORDS),
        .RVM_STAGES      (RVM_STAGES)
    ) dut_i (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic word_t alu_model(input alu_op_e op, input word_t a, input word_t b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    function automatic logic branch_taken(input alu_op_e op, input word_t a, input word_t b);
        case (op)
            BEQ:     return a == b;
            BNE:     return a != b;
            BLT:     return $signed(a) < $signed(b);
            default: return 1'b0;
        endcase
    endfunction

    function automatic word_t load_value(input word_t w, input logic [1:0] lane,
                                         input mem_size_e size, input logic sign);
        logic [7:0] b;
        b = w[8*lane +: 8];
        if (size == MEM_WORD) begin
            return w;
        end
        return sign ? {{24{b[7]}}, b} : {24'b0, b};
    endfunction

    function automatic word_t operand(input bypass_sel_e sel, input word_t raw);
        case (sel)
            BY_EX:   return m_ex_data;
            BY_MEM:  return m_mem_data;
            BY_RVM5: return m_rvm_res[RVM_STAGES];
            default: return raw;
        endcase
    endfunction

    // A source is only forwarded from while it is writing
    function automatic logic source_ready(input bypass_sel_e sel);
        case (sel)
            BY_EX:   return m_ex_we;
            BY_MEM:  return m_mem_we;
            BY_RVM5: return m_rvm_we[RVM_STAGES];
            default: return 1'b1;
        endcase
    endfunction

    // EX writes x1 to x10, MEM x11 to x20 and RVM x21 to x31
    function automatic op_t alu_rand();
        op_t op;
        op       = '0;
        op.alu   = alu_op_e'($urandom_range(7, 0));
        op.a     = $urandom();
        op.b     = $urandom();
        op.we    = 1'b1;
        op.waddr = reg_addr_t'($urandom_range(10, 1));
        return op;
    endfunction

    function automatic op_t branch_rand();
        op_t op;
        op       = alu_rand();
        op.alu   = alu_op_e'($urandom_range(10, 8));
        op.b     = ($urandom_range(1, 0) == 1) ? op.a : $urandom();
        op.base  = $urandom();
        op.off   = $urandom();
        op.we    = 1'($urandom_range(1, 0));
        return op;
    endfunction

    function automatic op_t mem_rand(input logic allow_store);
        op_t   op;
        word_t addr;
        op       = '0;
        op.pipe  = MEM_PIPE;
        op.size  = mem_size_e'($urandom_range(1, 0));
        // Stores keep rf_we high and must still leave mem_we_o low
        op.we    = 1'b1;
        op.waddr = reg_addr_t'($urandom_range(20, 11));
        addr     = word_t'($urandom_range(63, 0));
        if (op.size == MEM_WORD) begin
            addr[1:0] = 2'b00;
        end
        op.a = word_t'($urandom_range(63, 0));
        op.b = addr - op.a;
        if (allow_store && $urandom_range(1, 0) == 1) begin
            op.wr = 1'b1;
            op.st = $urandom();
        end else begin
            op.rd   = 1'b1;
            op.sign = 1'($urandom_range(1, 0));
        end
        return op;
    endfunction

    function automatic op_t mul_rand();
        op_t op;
        op       = '0;
        op.pipe  = RVM_PIPE;
        op.rvm   = rvm_op_e'($urandom_range(1, 0));
        op.a     = $urandom();
        op.b     = $urandom();
        op.we    = 1'b1;
        op.waddr = reg_addr_t'($urandom_range(31, 21));
        return op;
    endfunction

    function automatic op_t mixed_rand(input logic fwd);
        op_t op;
        case ($urandom_range(2, 0))
            0:       op = ($urandom_range(3, 0) == 0) ? branch_rand() : alu_rand();
            1:       op = mem_rand(!fwd);
            default: op = mul_rand();
        endcase
        // Strobes on a non-MEM op must be gated off
        if (op.pipe != MEM_PIPE) begin
            op.rd = 1'($urandom_range(1, 0));
            op.wr = 1'($urandom_range(1, 0));
        end
        if (fwd) begin
            op.bya = bypass_sel_e'($urandom_range(3, 0));
            op.byb = bypass_sel_e'($urandom_range(3, 0));
        end else begin
            op.we = 1'($urandom_range(1, 0));
        end
        return op;
    endfunction

    task automatic drive_op(input op_t op);
        pipe_i         <= op.pipe;
        alu_op_i       <= op.alu;
        rvm_op_i       <= op.rvm;
        mem_rd_i       <= op.rd;
        mem_wr_i       <= op.wr;
        mem_size_i     <= op.size;
        mem_sign_ext_i <= op.sign;
        src_a_i        <= op.a;
        src_b_i        <= op.b;
        st_data_i      <= op.st;
        br_base_i      <= op.base;
        br_offset_i    <= op.off;
        bypass_a_i     <= op.bya;
        bypass_b_i     <= op.byb;
        rf_we_i        <= op.we;
        rf_waddr_i     <= op.waddr;
    endtask

    // Model of one rising edge that samples the operation applied in the last cycle
    task automatic advance_model();
        word_t              fa;
        word_t              fb;
        word_t              addr;
        logic signed [63:0] prod;
        logic               is_br;
        fa = operand(app.bya, app.a);
        fb = operand(app.byb, app.b);
        for (int s = RVM_STAGES; s > 1; s--) begin
            m_rvm_we[s]    = m_rvm_we[s-1];
            m_rvm_waddr[s] = m_rvm_waddr[s-1];
            m_rvm_res[s]   = m_rvm_res[s-1];
        end
        prod           = longint'($signed(fa)) * longint'($signed(fb));
        m_rvm_we[1]    = (app.pipe == RVM_PIPE) && app.we;
        m_rvm_waddr[1] = app.waddr;
        m_rvm_res[1]   = (app.rvm == MULH) ? prod[63:32] : prod[31:0];

        m_mem_we    = m_s1_we;
        m_mem_waddr = m_s1_waddr;
        if (m_s1_rd) begin
            m_mem_data = load_value(model_mem[m_s1_idx], m_s1_lane, m_s1_size, m_s1_sign);
        end
        if (m_s1_wr && m_s1_size == MEM_WORD) begin
            model_mem[m_s1_idx] = m_s1_st;
        end else if (m_s1_wr) begin
            model_mem[m_s1_idx][8*m_s1_lane +: 8] = m_s1_st[7:0];
        end
        addr       = fa + fb;
        m_s1_idx   = addr[IDX_W+1:2];
        m_s1_lane  = addr[1:0];
        m_s1_size  = app.size;
        m_s1_sign  = app.sign;
        m_s1_st    = app.st;
        m_s1_rd    = (app.pipe == MEM_PIPE) && app.rd;
        m_s1_wr    = (app.pipe == MEM_PIPE) && app.wr;
        m_s1_we    = m_s1_rd && app.we;
        m_s1_waddr = app.waddr;

        is_br      = app.alu inside {BEQ, BNE, BLT};
        m_ex_data  = alu_model(app.alu, fa, fb);
        m_ex_we    = (app.pipe == EX_PIPE) && app.we && !is_br;
        m_ex_waddr = app.waddr;
        m_br_done  = (app.pipe == EX_PIPE) && is_br;
        m_tkbr     = m_br_done && branch_taken(app.alu, fa, fb);
        m_new_pc   = app.base + app.off;
    endtask

    task automatic compare(input string what, input word_t exp, input word_t act);
        num_checks++;
        if (act !== exp) begin
            num_errors++;
            $display("Mismatch in %s, %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_outputs();
        compare("ex_we", 32'(m_ex_we), 32'(ex_we_o));
        if (m_ex_we) begin
            compare("ex_waddr", 32'(m_ex_waddr), 32'(ex_waddr_o));
            compare("ex_data", m_ex_data, ex_data_o);
        end
        compare("branch_completed", 32'(m_br_done), 32'(branch_completed_o));
        compare("tkbr", 32'(m_tkbr), 32'(tkbr_o));
        if (m_br_done) begin
            compare("new_pc", m_new_pc, new_pc_o);
        end
        compare("mem_we", 32'(m_mem_we), 32'(mem_we_o));
        if (m_mem_we) begin
            compare("mem_waddr", 32'(m_mem_waddr), 32'(mem_waddr_o));
            compare("mem_data", m_mem_data, mem_data_o);
        end
        compare("rvm_we", 32'(m_rvm_we[RVM_STAGES]), 32'(rvm_we_o));
        if (m_rvm_we[RVM_STAGES]) begin
            compare("rvm_waddr", 32'(m_rvm_waddr[RVM_STAGES]), 32'(rvm_waddr_o));
            compare("rvm_data", m_rvm_res[RVM_STAGES], rvm_data_o);
        end
        compare("byp_ex_wreg", 32'(m_ex_we ? m_ex_waddr : '0), 32'(byp_ex_wreg_o));
        compare("byp_alu_mem_wreg", 32'(m_s1_we ? m_s1_waddr : '0), 32'(byp_alu_mem_wreg_o));
        compare("byp_mem_wreg", 32'(m_mem_we ? m_mem_waddr : '0), 32'(byp_mem_wreg_o));
        for (int s = 1; s <= RVM_STAGES; s++) begin
            compare($sformatf("byp_rvm_wreg[%0d]", s),
                    32'(m_rvm_we[s] ? m_rvm_waddr[s] : '0), 32'(byp_rvm_wreg_o[s]));
        end
        compare("byp_ex_data", m_ex_we ? m_ex_data : '0, byp_ex_data_o);
        compare("byp_mem_data", m_mem_we ? m_mem_data : '0, byp_mem_data_o);
        compare("byp_rvm5_data", m_rvm_we[RVM_STAGES] ? m_rvm_res[RVM_STAGES] : '0,
                byp_rvm5_data_o);
    endtask

    task automatic run_cycle(input op_t nxt);
        op_t op;
        @(posedge clk_i);
        advance_model();
        op = nxt;
        if (!source_ready(op.bya)) begin
            op.bya = NO_BYPASS;
        end
        if (!source_ready(op.byb)) begin
            op.byb = NO_BYPASS;
        end
        drive_op(op);
        app = op;
        @(negedge clk_i);
        check_outputs();
    endtask

    task automatic start_test(input string name);
        cur_test      = name;
        errs_at_start = num_errors;
    endtask

    task automatic end_test();
        repeat (DRAIN_CYCLES) run_cycle('0);
        num_tests++;
        $display("Test %-14s done, %0d mismatches", cur_test, num_errors - errs_at_start);
    endtask

    initial begin
        op_t op;
        void'($urandom(32'h237f_c6dd));
        drive_op('0);
        rst_n_i <= 1'b0;
        app      = '0;
        m_ex_we  = 1'b0;
        m_br_done = 1'b0;
        m_tkbr   = 1'b0;
        m_s1_rd  = 1'b0;
        m_s1_wr  = 1'b0;
        m_s1_we  = 1'b0;
        m_mem_we = 1'b0;
        for (int s = 1; s <= RVM_STAGES; s++) begin
            m_rvm_we[s] = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_n_i <= 1'b1;

        start_test("ex_alu");
        repeat (N_ALU) run_cycle(alu_rand());
        end_test();

        start_test("branches");
        repeat (N_BRANCH) run_cycle(branch_rand());
        end_test();

        start_test("memory");
        // Word stores fill the whole memory first
        for (int i = 0; i < N_MEM_INIT; i++) begin
            op      = '0;
            op.pipe = MEM_PIPE;
            op.wr   = 1'b1;
            op.size = MEM_WORD;
            op.a    = word_t'(i * 4);
            op.st   = $urandom();
            run_cycle(op);
        end
        repeat (N_MEM) run_cycle(mem_rand(1'b1));
        end_test();

        start_test("multiplier");
        repeat (N_MUL) run_cycle(mul_rand());
        end_test();

        start_test("forwarding");
        repeat (N_FWD) run_cycle(mixed_rand(1'b1));
        end_test();

        start_test("bypass_report");
        repeat (N_REPORT) run_cycle(mixed_rand(1'b0));
        end_test();

        $display("Tests run: %0d, checks: %0d, mismatches: %0d",
                 num_tests, num_checks, num_errors);
        if (num_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #((TOTAL_CYCLES + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Watchdog expired in test %s before all tests completed", cur_test);
        $display("Simulation finished: FAIL");
        $finish;
    end
endmodule : pipeline_wrapper_tb

/* src.f */
verilog/backend_op_pkg.sv
verilog/backend_data_pkg.sv
verilog/issue_if.sv
verilog/ex_stage.sv
verilog/mem_pipeline.sv
verilog/rvm_pipeline.sv
verilog/pipeline_wrapper.sv
sim/pipeline_wrapper_assertions.sv
sim/pipeline_wrapper_tb.sv

/* verilog/backend_data_pkg.sv */
package backend_data_pkg;

    localparam int WORD_W = 32;
    localparam int REG_ADDR_W = 5;
    localparam int PC_W = 32;

    // Register file data and ALU operands
    typedef logic [WORD_W-1:0] word_t;

    // x0 is hardwired, writes to it are dropped by the register file
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef logic [PC_W-1:0] pc_t;

endpackage : backend_data_pkg

/* verilog/backend_op_pkg.sv */
package backend_op_pkg;

    typedef enum logic [1:0] {
        EX_PIPE,
        MEM_PIPE,
        RVM_PIPE
    } pipe_sel_e;

    // Operand source, register file value or a pipeline result
    typedef enum logic [1:0] {
        NO_BYPASS,
        BY_EX,
        BY_MEM,
        BY_RVM5
    } bypass_sel_e;

    // Branch encodings resolve in EX and never write the register file
    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLL, SRL, SLT,
        BEQ, BNE, BLT
    } alu_op_e;

    typedef enum logic {MUL, MULH} rvm_op_e;

    typedef enum logic {MEM_BYTE, MEM_WORD} mem_size_e;

endpackage : backend_op_pkg

/* verilog/ex_stage.sv */
module ex_stage (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    issue_if.stage                      iss,
    output backend_data_pkg::word_t     res_o,
    output logic                        we_o,
    output backend_data_pkg::reg_addr_t waddr_o,
    output logic                        branch_completed_o,
    output logic                        tkbr_o,
    output backend_data_pkg::pc_t       new_pc_o
);
    import backend_op_pkg::*;
    import backend_data_pkg::*;

    word_t alu_res;
    logic  is_branch;
    logic  taken;

    always_comb begin
        alu_res   = '0;
        is_branch = 1'b0;
        taken     = 1'b0;
        case (iss.alu_op)
            ADD: alu_res = iss.src_a + iss.src_b;
            SUB: alu_res = iss.src_a - iss.src_b;
            AND: alu_res = iss.src_a & iss.src_b;
            OR:  alu_res = iss.src_a | iss.src_b;
            XOR: alu_res = iss.src_a ^ iss.src_b;
            SLL: alu_res = iss.src_a << iss.src_b[4:0];
            SRL: alu_res = iss.src_a >> iss.src_b[4:0];
            SLT: alu_res = {31'b0, $signed(iss.src_a) < $signed(iss.src_b)};
            BEQ: begin
                is_branch = 1'b1;
                taken     = (iss.src_a == iss.src_b);
            end
            BNE: begin
                is_branch = 1'b1;
                taken     = (iss.src_a != iss.src_b);
            end
            BLT: begin
                is_branch = 1'b1;
                taken     = $signed(iss.src_a) < $signed(iss.src_b);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            we_o               <= 1'b0;
            waddr_o            <= '0;
            branch_completed_o <= 1'b0;
            tkbr_o             <= 1'b0;
        end else begin
            we_o               <= iss.op_valid & iss.rf_we & ~is_branch;
            waddr_o            <= iss.rf_waddr;
            branch_completed_o <= iss.op_valid & is_branch;
            tkbr_o             <= iss.op_valid & is_branch & taken;
        end
    end

    // Target is only looked at while branch_completed_o is high
    always_ff @(posedge clk_i) begin
        res_o    <= alu_res;
        new_pc_o <= iss.br_base + iss.br_offset;
    end
endmodule : ex_stage

/* verilog/issue_if.sv */
interface issue_if;
    import backend_op_pkg::*;
    import backend_data_pkg::*;

    logic      op_valid;
    alu_op_e   alu_op;
    rvm_op_e   rvm_op;
    logic      mem_rd;
    logic      mem_wr;
    mem_size_e mem_size;
    logic      mem_sign_ext;
    word_t     src_a;
    word_t     src_b;
    word_t     st_data;
    pc_t       br_base;
    pc_t       br_offset;
    logic      rf_we;
    reg_addr_t rf_waddr;

    modport driver (
        output op_valid, alu_op, rvm_op, mem_rd, mem_wr, mem_size, mem_sign_ext,
        output src_a, src_b, st_data, br_base, br_offset, rf_we, rf_waddr
    );

    modport stage (
        input op_valid, alu_op, rvm_op, mem_rd, mem_wr, mem_size, mem_sign_ext,
        input src_a, src_b, st_data, br_base, br_offset, rf_we, rf_waddr
    );
endinterface : issue_if

/* verilog/mem_pipeline.sv */
module mem_pipeline #(
    parameter int MEM_DEPTH_WORDS = 256
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    issue_if.stage                      iss,
    output backend_data_pkg::word_t     data_o,
    output logic                        we_o,
    output backend_data_pkg::reg_addr_t waddr_o,
    output logic                        s1_we_o,
    output backend_data_pkg::reg_addr_t s1_waddr_o
);
    import backend_op_pkg::*;
    import backend_data_pkg::*;

    localparam int IDX_W = $clog2(MEM_DEPTH_WORDS);

    word_t            mem [MEM_DEPTH_WORDS];
    word_t            addr;
    logic [IDX_W-1:0] s1_idx;
    logic [1:0]       s1_lane;
    logic             s1_rd;
    logic             s1_wr;
    mem_size_e        s1_size;
    logic             s1_sign;
    word_t            s1_st_data;
    word_t            s2_word;
    logic [1:0]       s2_lane;
    mem_size_e        s2_size;
    logic             s2_sign;
    logic [7:0]       s2_byte;

    // Byte address
    assign addr = iss.src_a + iss.src_b;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            s1_rd      <= 1'b0;
            s1_wr      <= 1'b0;
            s1_we_o    <= 1'b0;
            s1_waddr_o <= '0;
            we_o       <= 1'b0;
            waddr_o    <= '0;
        end else begin
            s1_rd      <= iss.op_valid & iss.mem_rd;
            s1_wr      <= iss.op_valid & iss.mem_wr;
            s1_we_o    <= iss.op_valid & iss.mem_rd & iss.rf_we;
            s1_waddr_o <= iss.rf_waddr;
            we_o       <= s1_we_o;
            waddr_o    <= s1_waddr_o;
        end
    end

    always_ff @(posedge clk_i) begin
        s1_idx     <= addr[IDX_W+1:2];
        s1_lane    <= addr[1:0];
        s1_size    <= iss.mem_size;
        s1_sign    <= iss.mem_sign_ext;
        s1_st_data <= iss.st_data;
    end

    // Access stage
    always_ff @(posedge clk_i) begin
        if (s1_rd) begin
            s2_word <= mem[s1_idx];
        end
        if (s1_wr) begin
            if (s1_size == MEM_WORD) begin
                mem[s1_idx] <= s1_st_data;
            end else begin
                mem[s1_idx][{s1_lane, 3'b000} +: 8] <= s1_st_data[7:0];
            end
        end
        s2_lane <= s1_lane;
        s2_size <= s1_size;
        s2_sign <= s1_sign;
    end

    always_comb begin
        s2_byte = s2_word[{s2_lane, 3'b000} +: 8];
        if (s2_size == MEM_WORD) begin
            data_o = s2_word;
        end else if (s2_sign) begin
            data_o = {{24{s2_byte[7]}}, s2_byte};
        end else begin
            data_o = {24'b0, s2_byte};
        end
    end
endmodule : mem_pipeline

/* verilog/pipeline_wrapper.sv */
module pipeline_wrapper #(
    parameter int MEM_DEPTH_WORDS = 256,
    parameter int RVM_STAGES      = 5
) (
    input  logic                          clk_i,
    input  logic                          rst_n_i,

    input  backend_op_pkg::pipe_sel_e     pipe_i,
    input  backend_op_pkg::alu_op_e       alu_op_i,
    input  backend_op_pkg::rvm_op_e       rvm_op_i,
    input  logic                          mem_rd_i,
    input  logic                          mem_wr_i,
    input  backend_op_pkg::mem_size_e     mem_size_i,
    input  logic                          mem_sign_ext_i,
    input  backend_data_pkg::word_t       src_a_i,
    input  backend_data_pkg::word_t       src_b_i,
    input  backend_data_pkg::word_t       st_data_i,
    input  backend_data_pkg::pc_t         br_base_i,
    input  backend_data_pkg::pc_t         br_offset_i,
    input  backend_op_pkg::bypass_sel_e   bypass_a_i,
    input  backend_op_pkg::bypass_sel_e   bypass_b_i,
    input  logic                          rf_we_i,
    input  backend_data_pkg::reg_addr_t   rf_waddr_i,

    output backend_data_pkg::word_t       ex_data_o,
    output logic                          ex_we_o,
    output backend_data_pkg::reg_addr_t   ex_waddr_o,
    output backend_data_pkg::word_t       mem_data_o,
    output logic                          mem_we_o,
    output backend_data_pkg::reg_addr_t   mem_waddr_o,
    output backend_data_pkg::word_t       rvm_data_o,
    output logic                          rvm_we_o,
    output backend_data_pkg::reg_addr_t   rvm_waddr_o,

    output logic                          branch_completed_o,
    output logic                          tkbr_o,
    output backend_data_pkg::pc_t         new_pc_o,

    output backend_data_pkg::reg_addr_t   byp_ex_wreg_o,
    output backend_data_pkg::reg_addr_t   byp_alu_mem_wreg_o,
    output backend_data_pkg::reg_addr_t   byp_mem_wreg_o,
    output backend_data_pkg::reg_addr_t   byp_rvm_wreg_o [1:RVM_STAGES],
    output backend_data_pkg::word_t       byp_ex_data_o,
    output backend_data_pkg::word_t       byp_mem_data_o,
    output backend_data_pkg::word_t       byp_rvm5_data_o
);
    import backend_op_pkg::*;
    import backend_data_pkg::*;

    word_t                opnd_a;
    word_t                opnd_b;
    logic                 alu_mem_we;
    reg_addr_t            alu_mem_waddr;
    logic [RVM_STAGES-1:1] rvm_stage_we;
    reg_addr_t            rvm_stage_waddr [1:RVM_STAGES-1];

    function automatic word_t fwd(input bypass_sel_e sel, input word_t opnd,
                                  input word_t ex_d, input word_t mem_d,
                                  input word_t rvm_d);
        case (sel)
            BY_EX:   return ex_d;
            BY_MEM:  return mem_d;
            BY_RVM5: return rvm_d;
            default: return opnd;
        endcase
    endfunction

    assign opnd_a = fwd(bypass_a_i, src_a_i, ex_data_o, mem_data_o, rvm_data_o);
    assign opnd_b = fwd(bypass_b_i, src_b_i, ex_data_o, mem_data_o, rvm_data_o);

    // One issue bundle per pipeline, indexed by pipe_sel_e
    issue_if iss [3] ();

    for (genvar p = 0; p < 3; p++) begin : g_issue
        logic sel;
        assign sel                 = (pipe_i == pipe_sel_e'(p));
        assign iss[p].op_valid     = sel;
        assign iss[p].rf_we        = sel & rf_we_i;
        assign iss[p].mem_rd       = sel & mem_rd_i;
        assign iss[p].mem_wr       = sel & mem_wr_i;
        assign iss[p].alu_op       = alu_op_i;
        assign iss[p].rvm_op       = rvm_op_i;
        assign iss[p].mem_size     = mem_size_i;
        assign iss[p].mem_sign_ext = mem_sign_ext_i;
        assign iss[p].src_a        = opnd_a;
        assign iss[p].src_b        = opnd_b;
        assign iss[p].st_data      = st_data_i;
        assign iss[p].br_base      = br_base_i;
        assign iss[p].br_offset    = br_offset_i;
        assign iss[p].rf_waddr     = rf_waddr_i;
    end

    ex_stage u_ex (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .iss                (iss[EX_PIPE]),
        .res_o              (ex_data_o),
        .we_o               (ex_we_o),
        .waddr_o            (ex_waddr_o),
        .branch_completed_o (branch_completed_o),
        .tkbr_o             (tkbr_o),
        .new_pc_o           (new_pc_o)
    );

    mem_pipeline #(.MEM_DEPTH_WORDS(MEM_DEPTH_WORDS)) u_mem (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .iss        (iss[MEM_PIPE]),
        .data_o     (mem_data_o),
        .we_o       (mem_we_o),
        .waddr_o    (mem_waddr_o),
        .s1_we_o    (alu_mem_we),
        .s1_waddr_o (alu_mem_waddr)
    );

    rvm_pipeline #(.RVM_STAGES(RVM_STAGES)) u_rvm (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .iss           (iss[RVM_PIPE]),
        .res_o         (rvm_data_o),
        .we_o          (rvm_we_o),
        .waddr_o       (rvm_waddr_o),
        .stage_we_o    (rvm_stage_we),
        .stage_waddr_o (rvm_stage_waddr)
    );

    // Report to decode, zero when the stage is not writing
    assign byp_ex_wreg_o      = ex_we_o ? ex_waddr_o : '0;
    assign byp_ex_data_o      = ex_we_o ? ex_data_o : '0;
    assign byp_alu_mem_wreg_o = alu_mem_we ? alu_mem_waddr : '0;
    assign byp_mem_wreg_o     = mem_we_o ? mem_waddr_o : '0;
    assign byp_mem_data_o     = mem_we_o ? mem_data_o : '0;
    assign byp_rvm5_data_o    = rvm_we_o ? rvm_data_o : '0;

    for (genvar s = 1; s < RVM_STAGES; s++) begin : g_rvm_byp
        assign byp_rvm_wreg_o[s] = rvm_stage_we[s] ? rvm_stage_waddr[s] : '0;
    end
    assign byp_rvm_wreg_o[RVM_STAGES] = rvm_we_o ? rvm_waddr_o : '0;
endmodule : pipeline_wrapper

/* verilog/rvm_pipeline.sv */
module rvm_pipeline #(
    parameter int RVM_STAGES = 5
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    issue_if.stage                      iss,
    output backend_data_pkg::word_t     res_o,
    output logic                        we_o,
    output backend_data_pkg::reg_addr_t waddr_o,
    output logic [RVM_STAGES-1:1]       stage_we_o,
    output backend_data_pkg::reg_addr_t stage_waddr_o [1:RVM_STAGES-1]
);
    import backend_op_pkg::*;
    import backend_data_pkg::*;

    logic signed [63:0]    prod_q  [1:RVM_STAGES-1];
    rvm_op_e               op_q    [1:RVM_STAGES-1];
    logic [RVM_STAGES:1]   we_q;
    reg_addr_t             waddr_q [1:RVM_STAGES];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            we_q <= '0;
            for (int s = 1; s <= RVM_STAGES; s++) begin
                waddr_q[s] <= '0;
            end
        end else begin
            we_q[1]    <= iss.op_valid & iss.rf_we;
            waddr_q[1] <= iss.rf_waddr;
            for (int s = 2; s <= RVM_STAGES; s++) begin
                we_q[s]    <= we_q[s-1];
                waddr_q[s] <= waddr_q[s-1];
            end
        end
    end

    // Full signed product up front, half select in the last stage
    always_ff @(posedge clk_i) begin
        prod_q[1] <= $signed(iss.src_a) * $signed(iss.src_b);
        op_q[1]   <= iss.rvm_op;
        for (int s = 2; s < RVM_STAGES; s++) begin
            prod_q[s] <= prod_q[s-1];
            op_q[s]   <= op_q[s-1];
        end
        res_o <= (op_q[RVM_STAGES-1] == MULH) ? prod_q[RVM_STAGES-1][63:32]
                                              : prod_q[RVM_STAGES-1][31:0];
    end

    assign we_o       = we_q[RVM_STAGES];
    assign waddr_o    = waddr_q[RVM_STAGES];
    assign stage_we_o = we_q[RVM_STAGES-1:1];

    always_comb begin
        for (int s = 1; s < RVM_STAGES; s++) begin
            stage_waddr_o[s] = waddr_q[s];
        end
    end
endmodule : rvm_pipeline
